// File: src/cdma_settings.svh
// CDMA build settings
`ifndef CDMA_SETTINGS_SVH
`define CDMA_SETTINGS_SVH

// AXI and descriptor widths
`define CDMA_ADDR_W 32
`define CDMA_DATA_W 32
`define CDMA_STRB_W 4
`define CDMA_LEN_W 16
`define CDMA_TAG_W 8

// burst and queue limits
`define CDMA_MAX_BURST_LEN 16
`define CDMA_STATUS_FIFO_AW 5
`define CDMA_WRITE_FIFO_AW 5

`endif

// File: src/cdma_pkg.sv
// CDMA shared types
`include "cdma_settings.svh"

package cdma_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [3:0] {
        NONE          = 4'd0,
        AXI_RD_SLVERR = 4'd4,
        AXI_RD_DECERR = 4'd5,
        AXI_WR_SLVERR = 4'd6,
        AXI_WR_DECERR = 4'd7
    } dma_error_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_START,
        RD_REQ
    } read_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_WRITE
    } write_state_e;

    typedef struct packed {
        logic [`CDMA_ADDR_W-1:0] src_addr;
        logic [`CDMA_ADDR_W-1:0] dst_addr;
        logic [`CDMA_LEN_W-1:0]  len;
        logic [`CDMA_TAG_W-1:0]  tag;
    } desc_req_t;

    typedef struct packed {
        logic [`CDMA_TAG_W-1:0] tag;
        dma_error_e             error;
    } desc_sts_t;

    // len is beats minus one, as on the AXI bus
    typedef struct packed {
        logic [`CDMA_ADDR_W-1:0] addr;
        logic [7:0]              len;
    } addr_req_t;

    typedef struct packed {
        logic [`CDMA_DATA_W-1:0] data;
        axi_resp_e               resp;
    } r_beat_t;

    typedef struct packed {
        logic [`CDMA_DATA_W-1:0] data;
        logic [`CDMA_STRB_W-1:0] strb;
        logic                    last;
    } w_beat_t;

    // last_bytes of 0 means the last beat is full
    typedef struct packed {
        logic [`CDMA_ADDR_W-1:0]          addr;
        logic [7:0]                       beat_count;
        logic [$clog2(`CDMA_STRB_W)-1:0]  last_bytes;
        logic                             last_transfer;
        logic [`CDMA_TAG_W-1:0]           tag;
    } xfer_cmd_t;

    typedef struct packed {
        logic [`CDMA_TAG_W-1:0] tag;
        axi_resp_e              resp;
        logic                   last;
    } status_entry_t;

endpackage

// File: src/cdma_read_planner.sv
// CDMA read planner
`timescale 1ns/1ps
`include "cdma_settings.svh"

module cdma_read_planner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  cdma_pkg::desc_req_t  desc_req,
    input  logic                 desc_req_valid,
    output logic                 desc_req_ready,
    output cdma_pkg::addr_req_t  ar,
    output logic                 arvalid,
    input  logic                 arready,
    output cdma_pkg::xfer_cmd_t  cmd,
    output logic                 cmd_valid,
    input  logic                 cmd_ready,
    input  logic                 burst_done
);
    import cdma_pkg::*;

    localparam int BEAT_SHIFT = $clog2(`CDMA_STRB_W);
    localparam int MAX_BURST_BYTES = `CDMA_MAX_BURST_LEN << BEAT_SHIFT;
    localparam int DEPTH = 2 ** `CDMA_STATUS_FIFO_AW;
    localparam logic [`CDMA_ADDR_W-1:0] ADDR_MASK = {`CDMA_ADDR_W{1'b1}} << BEAT_SHIFT;

    read_state_e                  state;
    logic [`CDMA_ADDR_W-1:0]      read_addr;
    logic [`CDMA_ADDR_W-1:0]      write_addr;
    logic [`CDMA_LEN_W-1:0]       op_count;
    logic [12:0]                  axi_count;
    logic [`CDMA_TAG_W-1:0]       tag;
    logic [`CDMA_STATUS_FIFO_AW:0] active_count;
    logic                         active_av;
    logic                         inc_active;
    logic [12:0]                  wr_chunk;
    logic [12:0]                  rd_chunk;

    // bytes up to the next burst cut: max burst size or 4 KB edge
    function automatic logic [12:0] chunk_size(input logic [`CDMA_ADDR_W-1:0] addr,
                                               input logic [`CDMA_LEN_W-1:0] count);
        logic [12:0] limit;
        limit = 13'h1000 - {1'b0, addr[11:0]};
        if (limit > 13'(MAX_BURST_BYTES))
            limit = 13'(MAX_BURST_BYTES);
        if (count <= `CDMA_LEN_W'(limit))
            return 13'(count);
        return limit;
    endfunction

    assign wr_chunk = chunk_size(write_addr, op_count);
    assign rd_chunk = chunk_size(read_addr, `CDMA_LEN_W'(axi_count));
    assign inc_active = (state == RD_START) && !cmd_valid && active_av;

    always_ff @(posedge clk) begin
        desc_req_ready <= 1'b0;
        if (cmd_ready)
            cmd_valid <= 1'b0;
        if (arready)
            arvalid <= 1'b0;

        case (state)
            RD_IDLE: begin
                if (desc_req_ready && desc_req_valid) begin
                    read_addr <= desc_req.src_addr & ADDR_MASK;
                    write_addr <= desc_req.dst_addr & ADDR_MASK;
                    op_count <= desc_req.len;
                    tag <= desc_req.tag;
                    state <= RD_START;
                end else begin
                    desc_req_ready <= enable && !cmd_valid && active_av;
                end
            end
            RD_START: begin
                // one write burst per command
                if (inc_active) begin
                    axi_count <= wr_chunk;
                    write_addr <= write_addr + `CDMA_ADDR_W'(wr_chunk);
                    op_count <= op_count - `CDMA_LEN_W'(wr_chunk);
                    cmd.addr <= write_addr;
                    cmd.beat_count <= 8'((wr_chunk - 13'd1) >> BEAT_SHIFT);
                    cmd.last_bytes <= wr_chunk[BEAT_SHIFT-1:0];
                    cmd.last_transfer <= op_count == `CDMA_LEN_W'(wr_chunk);
                    cmd.tag <= tag;
                    cmd_valid <= 1'b1;
                    state <= RD_REQ;
                end
            end
            RD_REQ: begin
                // source side may need more than one read for this burst
                if (!arvalid) begin
                    ar.addr <= read_addr;
                    ar.len <= 8'((rd_chunk - 13'd1) >> BEAT_SHIFT);
                    arvalid <= 1'b1;
                    read_addr <= read_addr + `CDMA_ADDR_W'(rd_chunk);
                    axi_count <= axi_count - rd_chunk;
                    if (axi_count != rd_chunk)
                        state <= RD_REQ;
                    else if (op_count != '0)
                        state <= RD_START;
                    else
                        state <= RD_IDLE;
                end
            end
            default: state <= RD_IDLE;
        endcase

        // bursts in flight, bounded by the status queue depth
        if (inc_active && !burst_done) begin
            active_count <= active_count + 1'b1;
            active_av <= active_count < DEPTH - 1;
        end else if (!inc_active && burst_done) begin
            active_count <= active_count - 1'b1;
            active_av <= 1'b1;
        end

        if (rst) begin
            state <= RD_IDLE;
            desc_req_ready <= 1'b0;
            arvalid <= 1'b0;
            cmd_valid <= 1'b0;
            active_count <= '0;
            active_av <= 1'b1;
        end
    end

endmodule

// File: src/cdma_write_engine.sv
// CDMA write engine
`timescale 1ns/1ps
`include "cdma_settings.svh"

module cdma_write_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  cdma_pkg::xfer_cmd_t      cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    output cdma_pkg::addr_req_t      aw,
    output logic                     awvalid,
    input  logic                     awready,
    input  cdma_pkg::r_beat_t        rd,
    input  logic                     rvalid,
    output logic                     rready,
    output cdma_pkg::w_beat_t        beat,
    output logic                     beat_valid,
    input  logic                     half_full,
    output logic                     sts_push,
    output cdma_pkg::status_entry_t  sts_entry
);
    import cdma_pkg::*;

    localparam int SHIFT_W = $clog2(`CDMA_STRB_W) + 1;
    localparam logic [`CDMA_STRB_W-1:0] STRB_ALL = '1;

    write_state_e                    state;
    logic [7:0]                      beat_count;
    logic [$clog2(`CDMA_STRB_W)-1:0] last_bytes;
    logic                            last_transfer;
    logic [`CDMA_TAG_W-1:0]          tag;
    axi_resp_e                       rresp;
    axi_resp_e                       rresp_next;
    logic                            last_beat;

    assign cmd_ready = (state == WR_IDLE) && !awvalid;
    assign last_beat = beat_count == 8'd0;

    assign beat_valid = rready && rvalid;
    assign beat.data = rd.data;
    assign beat.last = last_beat;
    // partial last word keeps only its low byte lanes
    assign beat.strb = (last_beat && last_bytes != '0)
                     ? STRB_ALL >> (SHIFT_W'(`CDMA_STRB_W) - SHIFT_W'(last_bytes))
                     : STRB_ALL;

    always_comb begin
        rresp_next = rresp;
        if (beat_valid && (rd.resp == SLVERR || rd.resp == DECERR))
            rresp_next = rd.resp;
    end

    assign sts_push = beat_valid && last_beat;
    assign sts_entry.tag = tag;
    assign sts_entry.resp = rresp_next;
    assign sts_entry.last = last_transfer;

    always_ff @(posedge clk) begin
        if (awready)
            awvalid <= 1'b0;
        rready <= 1'b0;
        rresp <= (sts_push && last_transfer) ? OKAY : rresp_next;

        case (state)
            WR_IDLE: begin
                if (cmd_valid && cmd_ready) begin
                    aw.addr <= cmd.addr;
                    aw.len <= cmd.beat_count;
                    awvalid <= 1'b1;
                    beat_count <= cmd.beat_count;
                    last_bytes <= cmd.last_bytes;
                    last_transfer <= cmd.last_transfer;
                    tag <= cmd.tag;
                    rready <= !half_full;
                    state <= WR_WRITE;
                end
            end
            WR_WRITE: begin
                rready <= !half_full;
                if (beat_valid) begin
                    beat_count <= beat_count - 8'd1;
                    if (last_beat) begin
                        rready <= 1'b0;
                        state <= WR_IDLE;
                    end
                end
            end
            default: state <= WR_IDLE;
        endcase

        if (rst) begin
            state <= WR_IDLE;
            awvalid <= 1'b0;
            rready <= 1'b0;
            rresp <= OKAY;
        end
    end

endmodule

// File: src/cdma_write_fifo.sv
// CDMA write data FIFO
`timescale 1ns/1ps
`include "cdma_settings.svh"

module cdma_write_fifo (
    input  logic               clk,
    input  logic               rst,
    input  cdma_pkg::w_beat_t  beat,
    input  logic               beat_valid,
    output cdma_pkg::w_beat_t  w,
    output logic               wvalid,
    input  logic               wready,
    output logic               half_full
);
    import cdma_pkg::*;

    localparam int AW = `CDMA_WRITE_FIFO_AW;

    w_beat_t       mem [2**AW];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;

    assign full = wr_ptr == (rd_ptr ^ {1'b1, {AW{1'b0}}});
    assign empty = wr_ptr == rd_ptr;

    always_ff @(posedge clk) begin
        if (beat_valid && !full)
            mem[wr_ptr[AW-1:0]] <= beat;
    end

    always_ff @(posedge clk) begin
        if (wready)
            wvalid <= 1'b0;
        half_full <= (wr_ptr - rd_ptr) >= (AW+1)'(2 ** (AW - 1));

        if (beat_valid && !full)
            wr_ptr <= wr_ptr + 1'b1;

        // output register reloads when empty or taken
        if (!empty && (!wvalid || wready)) begin
            w <= mem[rd_ptr[AW-1:0]];
            wvalid <= 1'b1;
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            wvalid <= 1'b0;
            half_full <= 1'b0;
        end
    end

endmodule

// File: src/cdma_status_queue.sv
// CDMA burst status queue
`timescale 1ns/1ps
`include "cdma_settings.svh"

module cdma_status_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sts_push,
    input  cdma_pkg::status_entry_t  sts_entry,
    input  cdma_pkg::axi_resp_e      bresp,
    input  logic                     bvalid,
    output logic                     bready,
    output logic                     burst_done,
    output cdma_pkg::desc_sts_t      desc_sts,
    output logic                     desc_sts_valid
);
    import cdma_pkg::*;

    localparam int AW = `CDMA_STATUS_FIFO_AW;

    status_entry_t  mem [2**AW];
    logic [AW:0]    wr_ptr;
    logic [AW:0]    rd_ptr;
    status_entry_t  head;
    logic           empty;
    axi_resp_e      bresp_sticky;
    axi_resp_e      bresp_next;
    dma_error_e     err;

    assign empty = wr_ptr == rd_ptr;
    assign head = mem[rd_ptr[AW-1:0]];
    assign burst_done = bready && bvalid;

    always_comb begin
        bresp_next = bresp_sticky;
        if (burst_done && (bresp == SLVERR || bresp == DECERR))
            bresp_next = bresp;
    end

    // read errors win over write errors
    always_comb begin
        if (head.resp == SLVERR)
            err = AXI_RD_SLVERR;
        else if (head.resp == DECERR)
            err = AXI_RD_DECERR;
        else if (bresp_next == SLVERR)
            err = AXI_WR_SLVERR;
        else if (bresp_next == DECERR)
            err = AXI_WR_DECERR;
        else
            err = NONE;
    end

    always_ff @(posedge clk) begin
        if (sts_push)
            mem[wr_ptr[AW-1:0]] <= sts_entry;
    end

    always_ff @(posedge clk) begin
        desc_sts_valid <= 1'b0;
        bresp_sticky <= bresp_next;
        bready <= !empty && !burst_done;

        if (sts_push)
            wr_ptr <= wr_ptr + 1'b1;

        if (burst_done) begin
            desc_sts.tag <= head.tag;
            desc_sts.error <= err;
            desc_sts_valid <= head.last;
            rd_ptr <= rd_ptr + 1'b1;
            if (head.last)
                bresp_sticky <= OKAY;
        end

        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            bready <= 1'b0;
            desc_sts_valid <= 1'b0;
            bresp_sticky <= OKAY;
        end
    end

endmodule

// File: src/cdma_top.sv
// AXI4 central DMA top
`timescale 1ns/1ps

module cdma_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  cdma_pkg::desc_req_t  desc_req,
    input  logic                 desc_req_valid,
    output logic                 desc_req_ready,
    output cdma_pkg::desc_sts_t  desc_sts,
    output logic                 desc_sts_valid,
    output cdma_pkg::addr_req_t  ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  cdma_pkg::r_beat_t    rd,
    input  logic                 rvalid,
    output logic                 rready,
    output cdma_pkg::addr_req_t  aw,
    output logic                 awvalid,
    input  logic                 awready,
    output cdma_pkg::w_beat_t    w,
    output logic                 wvalid,
    input  logic                 wready,
    input  cdma_pkg::axi_resp_e  bresp,
    input  logic                 bvalid,
    output logic                 bready
);
    import cdma_pkg::*;

    xfer_cmd_t      cmd;
    logic           cmd_valid;
    logic           cmd_ready;
    w_beat_t        beat;
    logic           beat_valid;
    logic           half_full;
    logic           sts_push;
    status_entry_t  sts_entry;
    logic           burst_done;

    cdma_read_planner u_read_planner (
        .clk(clk), .rst(rst), .enable(enable),
        .desc_req(desc_req), .desc_req_valid(desc_req_valid),
        .desc_req_ready(desc_req_ready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .burst_done(burst_done)
    );

    cdma_write_engine u_write_engine (
        .clk(clk), .rst(rst),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .rd(rd), .rvalid(rvalid), .rready(rready),
        .beat(beat), .beat_valid(beat_valid), .half_full(half_full),
        .sts_push(sts_push), .sts_entry(sts_entry)
    );

    cdma_write_fifo u_write_fifo (
        .clk(clk), .rst(rst),
        .beat(beat), .beat_valid(beat_valid),
        .w(w), .wvalid(wvalid), .wready(wready),
        .half_full(half_full)
    );

    cdma_status_queue u_status_queue (
        .clk(clk), .rst(rst),
        .sts_push(sts_push), .sts_entry(sts_entry),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .burst_done(burst_done),
        .desc_sts(desc_sts), .desc_sts_valid(desc_sts_valid)
    );

endmodule

// File: tests/axi_mem_model.sv
// AXI slave memory model
`timescale 1ns/1ps
`include "cdma_settings.svh"

module axi_mem_model #(
    parameter int SEED = 1,
    parameter int RD_ERR_LO = 'h8000,
    parameter int RD_ERR_HI = 'h8100,
    parameter int WR_ERR_LO = 'h9000,
    parameter int WR_ERR_HI = 'h9100
) (
    input  logic                 clk,
    input  logic                 rst,
    input  int                   stall_pct,
    input  int                   slow_pct,
    input  cdma_pkg::addr_req_t  ar,
    input  logic                 arvalid,
    output logic                 arready,
    output cdma_pkg::r_beat_t    rd,
    output logic                 rvalid,
    input  logic                 rready,
    input  cdma_pkg::addr_req_t  aw,
    input  logic                 awvalid,
    output logic                 awready,
    input  cdma_pkg::w_beat_t    w,
    input  logic                 wvalid,
    output logic                 wready,
    output cdma_pkg::axi_resp_e  bresp,
    output logic                 bvalid,
    input  logic                 bready,
    output int                   err_count
);
    import cdma_pkg::*;

    localparam int BYTES = `CDMA_STRB_W;

    logic [7:0]  mem [0:65535];
    addr_req_t   ar_q [$];
    addr_req_t   aw_q [$];
    axi_resp_e   b_q [$];
    int          seed = SEED;
    int          rd_left;
    int          wr_left;
    logic [15:0] rd_addr;
    logic [15:0] wr_addr;
    logic        wr_err;

    // handshakes seen at the rising edge
    logic        ar_fire;
    logic        aw_fire;
    logic        r_fire;
    logic        w_fire;
    logic        b_fire;
    addr_req_t   ar_s;
    addr_req_t   aw_s;
    w_beat_t     w_s;

    initial begin
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(a ^ ((a >> 8) * 5));
        err_count = 0;
        arready = 1'b0;
        awready = 1'b0;
        rvalid = 1'b0;
        rd = '0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = OKAY;
    end

    function automatic bit ready_roll(input int pct);
        return ({$random(seed)} % 100) >= pct;
    endfunction

    function automatic bit in_window(input logic [15:0] a, input int lo, input int hi);
        return int'(a) >= lo && int'(a) < hi;
    endfunction

    task automatic check_burst(input string ch, input addr_req_t req);
        assert (req.len < `CDMA_MAX_BURST_LEN) else begin
            err_count++;
            $display("Error at %0t: %s burst of %0d beats is too long", $time, ch, req.len + 1);
        end
        assert (int'(req.addr[11:0]) + (int'(req.len) + 1) * BYTES <= 4096) else begin
            err_count++;
            $display("Error at %0t: %s burst at %h crosses 4 KB", $time, ch, req.addr);
        end
    endtask

    task automatic store_beat(input w_beat_t b);
        for (int i = 0; i < BYTES; i++)
            if (b.strb[i] && !in_window(wr_addr, WR_ERR_LO, WR_ERR_HI))
                mem[wr_addr + 16'(i)] = b.data[8*i +: 8];
        if (in_window(wr_addr, WR_ERR_LO, WR_ERR_HI))
            wr_err = 1'b1;
        assert (b.last == (wr_left == 1)) else begin
            err_count++;
            $display("Error at %0t: W last flag %0b at %h", $time, b.last, wr_addr);
        end
        assert (b.last || b.strb == '1) else begin
            err_count++;
            $display("Error at %0t: partial strobe %b before last beat", $time, b.strb);
        end
        wr_left--;
        wr_addr += 16'(BYTES);
        if (wr_left == 0)
            b_q.push_back(wr_err ? DECERR : OKAY);
    endtask

    always @(posedge clk) begin
        ar_fire <= arvalid && arready;
        aw_fire <= awvalid && awready;
        r_fire <= rvalid && rready;
        w_fire <= wvalid && wready;
        b_fire <= bvalid && bready;
        ar_s <= ar;
        aw_s <= aw;
        w_s <= w;
    end

    always @(negedge clk) begin
        if (rst) begin
            ar_q.delete();
            aw_q.delete();
            b_q.delete();
            rd_left = 0;
            wr_left = 0;
            arready = 1'b0;
            awready = 1'b0;
            rvalid = 1'b0;
            wready = 1'b0;
            bvalid = 1'b0;
        end else begin
            if (ar_fire) begin
                check_burst("AR", ar_s);
                ar_q.push_back(ar_s);
            end
            if (aw_fire) begin
                check_burst("AW", aw_s);
                aw_q.push_back(aw_s);
            end
            if (r_fire) begin
                rd_left--;
                rd_addr += 16'(BYTES);
            end
            if (w_fire)
                store_beat(w_s);

            // a read beat holds until taken
            if (!rvalid || r_fire) begin
                rvalid = 1'b0;
                if (rd_left == 0 && ar_q.size() > 0) begin
                    rd_addr = ar_q[0].addr[15:0];
                    rd_left = int'(ar_q[0].len) + 1;
                    void'(ar_q.pop_front());
                end
                if (rd_left > 0 && ready_roll(stall_pct)) begin
                    for (int i = 0; i < BYTES; i++)
                        rd.data[8*i +: 8] = mem[rd_addr + 16'(i)];
                    rd.resp = in_window(rd_addr, RD_ERR_LO, RD_ERR_HI) ? SLVERR : OKAY;
                    rvalid = 1'b1;
                end
            end

            // write data waits for its address
            if (wr_left == 0 && aw_q.size() > 0) begin
                wr_addr = aw_q[0].addr[15:0];
                wr_left = int'(aw_q[0].len) + 1;
                wr_err = 1'b0;
                void'(aw_q.pop_front());
            end
            wready = wr_left > 0 && ready_roll(slow_pct);

            if (!bvalid || b_fire) begin
                bvalid = 1'b0;
                if (b_q.size() > 0 && ready_roll(slow_pct)) begin
                    bresp = b_q.pop_front();
                    bvalid = 1'b1;
                end
            end

            arready = ready_roll(stall_pct);
            awready = ready_roll(stall_pct);
        end
    end

endmodule

// File: tests/cdma_tb.sv
// CDMA testbench
`timescale 1ns/1ps
`include "cdma_settings.svh"

module cdma_tb;
    import cdma_pkg::*;

    localparam int SEED_INIT = 32'h5486_d097;
    localparam int TIMEOUT = 20000;
    localparam int LONG_TIMEOUT = 60000;
    localparam int RD_ERR_LO = 'h8000;
    localparam int RD_ERR_HI = 'h8100;
    localparam int WR_ERR_LO = 'h9000;
    localparam int WR_ERR_HI = 'h9100;

    logic       clk = 1'b0;
    logic       rst;
    logic       enable;
    desc_req_t  desc_req;
    logic       desc_req_valid;
    logic       desc_req_ready;
    desc_sts_t  desc_sts;
    logic       desc_sts_valid;
    addr_req_t  ar;
    logic       arvalid;
    logic       arready;
    r_beat_t    rd;
    logic       rvalid;
    logic       rready;
    addr_req_t  aw;
    logic       awvalid;
    logic       awready;
    w_beat_t    w;
    logic       wvalid;
    logic       wready;
    axi_resp_e  bresp;
    logic       bvalid;
    logic       bready;
    int         stall_pct;
    int         slow_pct;
    int         mem_errors;

    int         seed = SEED_INIT;
    int         errors = 0;
    bit         aborted = 1'b0;
    int         n_sent = 0;
    int         n_sts = 0;
    logic [`CDMA_TAG_W-1:0] next_tag = '0;
    logic [7:0] ref_mem [0:65535];
    desc_sts_t  exp_q [$];
    desc_sts_t  exp_sts;

    always #20 clk = ~clk;

    cdma_top u_cdma_top (.*);

    axi_mem_model #(
        .SEED(SEED_INIT),
        .RD_ERR_LO(RD_ERR_LO), .RD_ERR_HI(RD_ERR_HI),
        .WR_ERR_LO(WR_ERR_LO), .WR_ERR_HI(WR_ERR_HI)
    ) u_mem (.*, .err_count(mem_errors));

    assert property (@(posedge clk) rst |=> !(desc_req_ready || arvalid || awvalid || wvalid
                                             || rready || bready || desc_sts_valid))
        else begin
            errors++;
            $display("Error at %0t: an output is active right after reset", $time);
        end

    assert property (@(posedge clk) disable iff (rst) !enable |=> !desc_req_ready)
        else begin
            errors++;
            $display("Error at %0t: desc_req_ready high while disabled", $time);
        end

    // valid holds until the handshake
    assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else begin
            errors++;
            $display("Error at %0t: arvalid dropped before arready", $time);
        end
    assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else begin
            errors++;
            $display("Error at %0t: awvalid dropped before awready", $time);
        end
    assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else begin
            errors++;
            $display("Error at %0t: wvalid dropped before wready", $time);
        end

    // the status pulse spans a full cycle, so the falling edge sees it once
    always @(negedge clk) begin
        if (!rst && desc_sts_valid) begin
            n_sts++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: status tag %0d with no descriptor pending",
                         $time, desc_sts.tag);
            end else begin
                exp_sts = exp_q.pop_front();
                assert (desc_sts == exp_sts) else begin
                    errors++;
                    $display("Error at %0t: status tag %0d %s, expected tag %0d %s", $time,
                             desc_sts.tag, desc_sts.error.name(),
                             exp_sts.tag, exp_sts.error.name());
                end
            end
        end
    end

    function automatic int pick(input int range);
        return {$random(seed)} % range;
    endfunction

    // half of the addresses sit just below a 4 KB edge
    function automatic logic [31:0] pick_addr(input int base);
        if (pick(2) == 0)
            return 32'(base + 'h1000 * (1 + pick(3)) - 4 * pick(12));
        return 32'(base + 4 * pick('hF00));
    endfunction

    function automatic bit overlaps(input logic [31:0] a, input int len, input int lo,
                                    input int hi);
        return int'(a) < hi && int'(a) + len > lo;
    endfunction

    task automatic report_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout: %s", what);
    endtask

    task automatic queue_desc(input logic [31:0] src, input logic [31:0] dst, input int len);
        desc_sts_t   exp;
        logic [31:0] a;
        exp.tag = next_tag;
        if (overlaps(src, len, RD_ERR_LO, RD_ERR_HI))
            exp.error = AXI_RD_SLVERR;
        else if (overlaps(dst, len, WR_ERR_LO, WR_ERR_HI))
            exp.error = AXI_WR_DECERR;
        else
            exp.error = NONE;
        // bytes aimed at the write-error window never land
        for (int i = 0; i < len; i++) begin
            a = dst + 32'(i);
            if (!(a >= WR_ERR_LO && a < WR_ERR_HI))
                ref_mem[a[15:0]] = ref_mem[16'(src + 32'(i))];
        end
        exp_q.push_back(exp);
        desc_req.src_addr = src;
        desc_req.dst_addr = dst;
        desc_req.len = `CDMA_LEN_W'(len);
        desc_req.tag = next_tag;
        desc_req_valid = 1'b1;
        next_tag++;
        n_sent++;
    endtask

    // ready seen at a falling edge still holds at the next rising edge
    task automatic wait_accept();
        int n;
        n = 0;
        while (!desc_req_ready && n < TIMEOUT && !aborted) begin
            @(negedge clk);
            n++;
        end
        if (!desc_req_ready && !aborted)
            report_timeout("descriptor was never accepted");
        @(negedge clk);
        desc_req_valid = 1'b0;
    endtask

    task automatic send(input logic [31:0] src, input logic [31:0] dst, input int len);
        if (!aborted) begin
            queue_desc(src, dst, len);
            wait_accept();
        end
    endtask

    task automatic wait_statuses(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < limit && !aborted) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0 && !aborted)
            report_timeout("descriptor statuses still missing");
    endtask

    initial begin
        rst = 1'b1;
        enable = 1'b0;
        desc_req = '0;
        desc_req_valid = 1'b0;
        stall_pct = 20;
        slow_pct = 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        enable = 1'b1;
        for (int a = 0; a < 65536; a++)
            ref_mem[a] = u_mem.mem[a];

        // random copies, sources below 0x4000 and destinations above
        for (int i = 0; i < 40; i++)
            send(pick_addr('h0000), pick_addr('h4000), 1 + pick(300));
        wait_statuses(LONG_TIMEOUT);

        // each error case is followed by a clean copy
        // the first two leave their window before the last burst
        send(RD_ERR_HI - 16, pick_addr('h4000), 100);
        send(pick_addr('h0000), pick_addr('h4000), 64);
        send(pick_addr('h0000), WR_ERR_HI - 8, 100);
        send(pick_addr('h0000), pick_addr('h4000), 37);
        send(RD_ERR_LO + 32, WR_ERR_LO + 64, 40);
        send(pick_addr('h0000), pick_addr('h4000), 90);
        wait_statuses(TIMEOUT);

        // descriptor offered while disabled
        enable = 1'b0;
        @(negedge clk);
        if (!aborted) begin
            queue_desc(pick_addr('h0000), pick_addr('h4000), 120);
            repeat (20) begin
                @(negedge clk);
                assert (!desc_req_ready && !arvalid) else begin
                    errors++;
                    $display("Error at %0t: engine active while disabled", $time);
                end
            end
            enable = 1'b1;
            wait_accept();
        end
        enable = 1'b1;
        wait_statuses(TIMEOUT);

        // long write and response stalls with many descriptors queued
        stall_pct = 30;
        slow_pct = 85;
        for (int i = 0; i < 12; i++)
            send(pick_addr('h0000), pick_addr('h4000), 200 + pick(101));
        wait_statuses(LONG_TIMEOUT);

        if (!aborted) begin
            assert (n_sts == n_sent) else begin
                errors++;
                $display("Error at %0t: %0d statuses for %0d descriptors", $time, n_sts,
                         n_sent);
            end
            for (int a = 0; a < 65536; a++)
                assert (u_mem.mem[a] == ref_mem[a]) else begin
                    errors++;
                    $display("Error at %0t: byte %h is %h, expected %h", $time, a,
                             u_mem.mem[a], ref_mem[a]);
                end
        end

        $display("%0d descriptors, %0d testbench errors, %0d memory model errors",
                 n_sent, errors, mem_errors);
        if (errors == 0 && mem_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/cdma_pkg.sv
src/cdma_read_planner.sv
src/cdma_write_engine.sv
src/cdma_write_fifo.sv
src/cdma_status_queue.sv
src/cdma_top.sv
tests/axi_mem_model.sv
tests/cdma_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module cdma_tb -o cdma_sim
	./obj_dir/cdma_sim | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
